//--- testbench/mul_stim.txt
# test_name operand_a operand_b expected_product, all values in hex
# zero, one, all ones and the 8 and 16 bit edges of each leaf tree
zero_times_x         00000000 deadbeef 0000000000000000
x_times_zero         12345678 00000000 0000000000000000
zero_times_zero      00000000 00000000 0000000000000000
one_times_x          00000001 89abcdef 0000000089abcdef
x_times_one          fedcba98 00000001 00000000fedcba98
ones_times_ones      ffffffff ffffffff fffffffe00000001
ones_times_two       ffffffff 00000002 00000001fffffffe
small_odd            00000003 00000005 000000000000000f
byte_max             000000ff 000000ff 000000000000fe01
byte_carry           00000100 00000100 0000000000010000
byte_top_bit         00000080 00000080 0000000000004000
byte_times_ones      000000ff ffffffff 000000feffffff01
upper_byte           0000ff00 0000ff00 00000000fe010000
half_max             0000ffff 0000ffff 00000000fffe0001
half_carry           00010000 00010000 0000000100000000
half_top_bit         00008000 00008000 0000000040000000
half_times_ones      0000ffff ffffffff 0000fffeffff0001
lo_times_hi          0000ffff ffff0000 0000fffe00010000
hi_times_lo          ffff0000 0000ffff 0000fffe00010000
hi_times_hi          ffff0000 ffff0000 fffe000100000000
carry_into_hi        00010000 ffffffff 0000ffffffff0000
word_top_bit         80000000 80000000 4000000000000000
top_bit_times_ones   80000000 ffffffff 7fffffff80000000
byte_lanes           00ff00ff ff00ff00 00fe02fc02fe0100
alt_bits_times_three aaaaaaaa 00000003 00000001fffffffe

//--- build.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/dadda_8x8.sv
rtl/dadda_16x16.sv
rtl/mul_sequencer.sv
rtl/mul_accumulator.sv
rtl/mul_top.sv
testbench/mul_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --timing --assert
SIM_FLAGS = --binary -Wno-fatal
TOP       = mul_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_TEXT = Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/mul_tb.sv
/* testbench for mul_top, directed cases from testbench/mul_stim.txt plus LFSR random pairs.
   run from the project root so the stimulus path resolves */
`timescale 1ns/10ps
`include "mul_consts.svh"

module mul_tb;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          DONE_TIMEOUT = 4 * `MUL_LATENCY;
    localparam int          RANDOM_TESTS = 200;
    localparam int          MAX_LINES    = 1000;
    localparam string       STIM_FILE    = "testbench/mul_stim.txt";
    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED    = 32'd13;

    logic              clk;
    logic              rst;
    logic              start;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    logic              busy;
    logic              done;
    mul_pkg::product_t product;
    logic              zero;

    logic        test_failed;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state;

    mul_top DUT (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a       (a),
        .b       (b),
        .busy    (busy),
        .done    (done),
        .product (product),
        .zero    (zero)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            lfsr_next = (state >> 1) ^ LFSR_TAPS;
        end else begin
            lfsr_next = state >> 1;
        end
    endfunction

    // one LFSR step per operand bit
    task automatic random_word(output mul_pkg::operand_t word);
        int i;
        word = '0;
        for (i = 0; i < `MUL_WIDTH; i++) begin
            word = {word[`MUL_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input mul_pkg::product_t expected,
                               input mul_pkg::product_t actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %h actual %h", name, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %b actual %b", name, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic check_count(input string name, input string what,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            $display("FAIL %s %s expected %0d actual %0d", name, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_failed) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s passed", name);
        end
        test_failed = 1'b0;
    endtask

    task automatic check_reset_state();
        check_bit("after_reset", "done", 1'b0, done);
        check_bit("after_reset", "busy", 1'b0, busy);
        check_value("after_reset", "product", '0, product);
        check_bit("after_reset", "zero", 1'b1, zero);
        close_test("after_reset");
    endtask

    // a second start two cycles in, with other operands, when intrude is set
    task automatic run_test(input string name, input mul_pkg::operand_t op_a,
                            input mul_pkg::operand_t op_b,
                            input mul_pkg::product_t expected, input logic intrude);
        int   cycles;
        int   extra;
        int   i;
        logic busy_held;
        @(negedge clk);
        start = 1'b1;
        a = op_a;
        b = op_b;
        cycles = 0;
        busy_held = 1'b1;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            busy_held = busy_held & busy;
            start = intrude && (cycles == 2);
            if (start) begin
                a = ~op_a;
                b = op_b ^ 32'h5a5a_5a5a;
            end
        end
        start = 1'b0;
        assert (done) else begin
            $display("test %s: done did not arrive within %0d cycles", name, DONE_TIMEOUT);
            test_failed = 1'b1;
        end
        if (done) begin
            check_count(name, "latency", `MUL_LATENCY, cycles);
            check_bit(name, "busy before done", 1'b1, busy_held);
            check_value(name, "product", expected, product);
            check_bit(name, "zero", expected == '0, zero);
            @(negedge clk);
            check_bit(name, "done after one cycle", 1'b0, done);
            check_bit(name, "busy after done", 1'b0, busy);
            if (intrude) begin
                extra = 0;
                for (i = 0; i < 2 * `MUL_LATENCY; i++) begin
                    @(negedge clk);
                    if (done) begin
                        extra++;
                    end
                end
                check_count(name, "extra done strobes", 0, extra);
                check_value(name, "held product", expected, product);
            end
        end
        close_test(name);
    endtask

    task automatic run_directed_file();
        int                fd;
        int                fields;
        int                lines;
        int                loaded;
        int                got;
        logic [8*160-1:0]  line_raw;
        logic [8*32-1:0]   name_raw;
        mul_pkg::operand_t op_a;
        mul_pkg::operand_t op_b;
        mul_pkg::product_t expected;
        loaded = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            test_failed = 1'b1;
            close_test("stim_file");
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                line_raw = '0;
                name_raw = '0;
                got = $fgets(line_raw, fd);
                lines++;
                // comment and blank lines never yield four fields
                fields = $sscanf(line_raw, "%s %h %h %h", name_raw, op_a, op_b, expected);
                if (got > 0 && fields == 4) begin
                    run_test($sformatf("%0s", name_raw), op_a, op_b, expected, 1'b0);
                    loaded++;
                end
            end
            $fclose(fd);
            if (loaded == 0) begin
                $display("no directed tests were found in %s", STIM_FILE);
                test_failed = 1'b1;
                close_test("stim_file");
            end
        end
    endtask

    initial begin
        mul_pkg::operand_t op_a;
        mul_pkg::operand_t op_b;
        int                i;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        a = '0;
        b = '0;
        test_failed = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        lfsr_state = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        run_directed_file();

        for (i = 0; i < RANDOM_TESTS; i++) begin
            random_word(op_a);
            random_word(op_b);
            run_test($sformatf("random_%0d", i), op_a, op_b,
                     mul_pkg::product_t'(op_a) * mul_pkg::product_t'(op_b), 1'b0);
        end

        op_a = 32'h0000_ffff;
        op_b = 32'h0001_0001;
        run_test("start_while_busy", op_a, op_b,
                 mul_pkg::product_t'(op_a) * mul_pkg::product_t'(op_b), 1'b1);

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- rtl/mul_top.sv
/* 32x32 unsigned multiplier, five edges from start to done.
   start is ignored while busy */
`timescale 1ns/10ps

module mul_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  mul_pkg::operand_t  a,
    input  mul_pkg::operand_t  b,
    output logic               busy,
    output logic               done,
    output mul_pkg::product_t  product,
    output logic               zero
);

    mul_pkg::half_t    a_half;
    mul_pkg::half_t    b_half;
    mul_pkg::step_t    step;
    mul_pkg::partial_t partial;
    logic              acc_clear;
    logic              acc_add;
    logic              last;

    mul_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .a         (a),
        .b         (b),
        .a_half    (a_half),
        .b_half    (b_half),
        .step      (step),
        .acc_clear (acc_clear),
        .acc_add   (acc_add),
        .last      (last),
        .busy      (busy),
        .done      (done)
    );

    dadda_16x16 u_array (
        .a_half  (a_half),
        .b_half  (b_half),
        .partial (partial)
    );

    mul_accumulator u_acc (
        .clk       (clk),
        .rst       (rst),
        .acc_clear (acc_clear),
        .acc_add   (acc_add),
        .last      (last),
        .step      (step),
        .partial   (partial),
        .product   (product),
        .zero      (zero)
    );

endmodule

//--- rtl/mul_accumulator.sv
/* sums the four partial products at their half-word offsets.
   product and zero hold the last result until the next one completes */
`timescale 1ns/10ps
`include "mul_consts.svh"

module mul_accumulator (
    input  logic               clk,
    input  logic               rst,
    input  logic               acc_clear,
    input  logic               acc_add,
    input  logic               last,
    input  mul_pkg::step_t     step,
    input  mul_pkg::partial_t  partial,
    output mul_pkg::product_t  product,
    output logic               zero
);

    mul_pkg::product_t sum;
    mul_pkg::product_t addend;
    mul_pkg::product_t sum_next;

    // shift is one half word per high half in the pair
    always_comb begin
        case (step)
            mul_pkg::step_t'(0): addend = {{`MUL_WIDTH{1'b0}}, partial};
            mul_pkg::step_t'(3): addend = {partial, {`MUL_WIDTH{1'b0}}};
            default: addend = {{`MUL_HALF{1'b0}}, partial, {`MUL_HALF{1'b0}}};
        endcase
    end

    assign sum_next = sum + addend;

    always_ff @(posedge clk) begin
        if (acc_clear) begin
            sum <= '0;
        end else if (acc_add) begin
            sum <= sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
            zero    <= 1'b1;
        end else if (last) begin
            product <= sum_next;
            zero    <= (sum_next == '0);
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(acc_clear && acc_add));

endmodule

//--- rtl/mul_sequencer.sv
/* steps one 16x16 array through the four half pairs of a 32x32 multiply.
   start is taken only while idle, a start seen while busy is dropped */
`timescale 1ns/10ps
`include "mul_consts.svh"

module mul_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  mul_pkg::operand_t  a,
    input  mul_pkg::operand_t  b,
    output mul_pkg::half_t     a_half,
    output mul_pkg::half_t     b_half,
    output mul_pkg::step_t     step,
    output logic               acc_clear,
    output logic               acc_add,
    output logic               last,
    output logic               busy,
    output logic               done
);

    mul_pkg::seq_state_t state;
    mul_pkg::operand_t   a_reg;
    mul_pkg::operand_t   b_reg;
    mul_pkg::step_t      step_next;

    assign busy      = (state != mul_pkg::IDLE);
    assign done      = (state == mul_pkg::DONE);
    assign acc_clear = start && !busy;
    assign last      = acc_add && (step == mul_pkg::step_t'(`MUL_STEPS - 1));
    assign step_next = step + mul_pkg::step_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mul_pkg::IDLE;
            step    <= '0;
            acc_add <= 1'b0;
        end else begin
            case (state)
                mul_pkg::IDLE: begin
                    if (start) begin
                        state   <= mul_pkg::RUN;
                        step    <= '0;
                        acc_add <= 1'b1;
                    end
                end
                mul_pkg::RUN: begin
                    if (last) begin
                        state   <= mul_pkg::DONE;
                        acc_add <= 1'b0;
                    end else begin
                        step <= step_next;
                    end
                end
                default: state <= mul_pkg::IDLE;
            endcase
        end
    end

    // step bit 1 picks the a half, bit 0 the b half
    always_ff @(posedge clk) begin
        if (acc_clear) begin
            a_reg  <= a;
            b_reg  <= b;
            a_half <= a[`MUL_HALF-1:0];
            b_half <= b[`MUL_HALF-1:0];
        end else if (acc_add && !last) begin
            a_half <= step_next[1] ? a_reg[`MUL_WIDTH-1:`MUL_HALF] : a_reg[`MUL_HALF-1:0];
            b_half <= step_next[0] ? b_reg[`MUL_WIDTH-1:`MUL_HALF] : b_reg[`MUL_HALF-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst) done |=> !done);

    assert property (@(posedge clk) disable iff (rst) (state == mul_pkg::IDLE) |-> !acc_add);

    // a start while busy must not disturb the step count
    assert property (@(posedge clk) disable iff (rst)
        (start && busy) |=> (step == $past(step) + mul_pkg::step_t'($past(acc_add && !last))));

    assert property (@(posedge clk) disable iff (rst) acc_clear |-> ##(`MUL_LATENCY) done);

endmodule

//--- rtl/dadda_16x16.sv
/* combinational 16x16 unsigned multiply from four 8x8 trees.
   the top carry out of bit 31 is always zero and is not kept */
`timescale 1ns/10ps
`include "mul_consts.svh"

module dadda_16x16 (
    input  mul_pkg::half_t    a_half,
    input  mul_pkg::half_t    b_half,
    output mul_pkg::partial_t partial
);

    logic [`MUL_HALF-1:0] y11, y12, y21, y22;
    // third row of the overlap, y11 high byte then y22 low byte
    logic [`MUL_HALF-1:0] row_x;
    logic [`MUL_HALF-1:0] s1, c1;
    logic [`MUL_HALF+5:0] c2;

    function automatic logic [1:0] fa(input logic x, input logic p, input logic q);
        fa = {(x & p) | (x & q) | (p & q), x ^ p ^ q};
    endfunction

    function automatic logic [1:0] ha(input logic x, input logic p);
        ha = {x & p, x ^ p};
    endfunction

    dadda_8x8 u_ll (.a(a_half[`MUL_LEAF-1:0]),         .b(b_half[`MUL_LEAF-1:0]),         .y(y11));
    dadda_8x8 u_lh (.a(a_half[`MUL_LEAF-1:0]),         .b(b_half[`MUL_HALF-1:`MUL_LEAF]), .y(y12));
    dadda_8x8 u_hl (.a(a_half[`MUL_HALF-1:`MUL_LEAF]), .b(b_half[`MUL_LEAF-1:0]),         .y(y21));
    dadda_8x8 u_hh (.a(a_half[`MUL_HALF-1:`MUL_LEAF]), .b(b_half[`MUL_HALF-1:`MUL_LEAF]), .y(y22));

    assign row_x = {y22[`MUL_LEAF-1:0], y11[`MUL_HALF-1:`MUL_LEAF]};

    always_comb begin
        partial[`MUL_LEAF-1:0] = y11[`MUL_LEAF-1:0];

        // 3:2 row over columns 8 to 23
        for (int k = 0; k < `MUL_HALF; k++) begin
            {c1[k], s1[k]} = fa(row_x[k], y12[k], y21[k]);
        end

        partial[8] = s1[0];
        {c2[0], partial[9]} = ha(s1[1], c1[0]);
        // each column takes the save carry from the column below
        for (int k = 2; k < `MUL_HALF; k++) begin
            {c2[k-1], partial[8+k]} = fa(s1[k], c1[k-1], c2[k-2]);
        end
        {c2[15], partial[24]} = fa(y22[8], c1[15], c2[14]);

        // carry runs on through the top byte of y22
        for (int k = 9; k < `MUL_HALF-1; k++) begin
            {c2[k+7], partial[16+k]} = ha(y22[k], c2[k+6]);
        end
        partial[31] = y22[15] ^ c2[21];
    end

endmodule

//--- rtl/dadda_8x8.sv
/* combinational 8x8 unsigned Dadda tree, heights 8-6-4-3-2 then a ripple carry row.
   no timing stages inside, the whole tree settles within one clock */
`timescale 1ns/10ps
`include "mul_consts.svh"

module dadda_8x8 (
    input  logic [`MUL_LEAF-1:0]   a,
    input  logic [`MUL_LEAF-1:0]   b,
    output logic [2*`MUL_LEAF-1:0] y
);

    // pp[i][j] has weight i + j
    logic [`MUL_LEAF-1:0] pp [`MUL_LEAF];

    logic [5:0]  s1, c1;
    logic [13:0] s2, c2;
    logic [9:0]  s3, c3;
    logic [11:0] s4, c4;
    logic [13:0] c5;

    // returns {carry, sum}
    function automatic logic [1:0] fa(input logic x, input logic p, input logic q);
        fa = {(x & p) | (x & q) | (p & q), x ^ p ^ q};
    endfunction

    function automatic logic [1:0] ha(input logic x, input logic p);
        ha = {x & p, x ^ p};
    endfunction

    for (genvar i = 0; i < `MUL_LEAF; i++) begin : g_pp
        assign pp[i] = a & {`MUL_LEAF{b[i]}};
    end

    // 8 -> 6
    assign {c1[0], s1[0]} = ha(pp[6][0], pp[5][1]);
    assign {c1[2], s1[2]} = ha(pp[4][3], pp[3][4]);
    assign {c1[4], s1[4]} = ha(pp[4][4], pp[3][5]);
    assign {c1[1], s1[1]} = fa(pp[7][0], pp[6][1], pp[5][2]);
    assign {c1[3], s1[3]} = fa(pp[7][1], pp[6][2], pp[5][3]);
    assign {c1[5], s1[5]} = fa(pp[7][2], pp[6][3], pp[5][4]);

    // 6 -> 4
    assign {c2[0], s2[0]}   = ha(pp[4][0], pp[3][1]);
    assign {c2[2], s2[2]}   = ha(pp[2][3], pp[1][4]);
    assign {c2[1], s2[1]}   = fa(pp[5][0], pp[4][1], pp[3][2]);
    assign {c2[3], s2[3]}   = fa(s1[0], pp[4][2], pp[3][3]);
    assign {c2[4], s2[4]}   = fa(pp[2][4], pp[1][5], pp[0][6]);
    assign {c2[5], s2[5]}   = fa(s1[1], s1[2], c1[0]);
    assign {c2[6], s2[6]}   = fa(pp[2][5], pp[1][6], pp[0][7]);
    assign {c2[7], s2[7]}   = fa(s1[3], s1[4], c1[1]);
    assign {c2[8], s2[8]}   = fa(c1[2], pp[2][6], pp[1][7]);
    assign {c2[9], s2[9]}   = fa(s1[5], c1[3], c1[4]);
    assign {c2[10], s2[10]} = fa(pp[4][5], pp[3][6], pp[2][7]);
    assign {c2[11], s2[11]} = fa(pp[7][3], c1[5], pp[6][4]);
    assign {c2[12], s2[12]} = fa(pp[5][5], pp[4][6], pp[3][7]);
    assign {c2[13], s2[13]} = fa(pp[7][4], pp[6][5], pp[5][6]);

    // 4 -> 3
    assign {c3[0], s3[0]} = ha(pp[3][0], pp[2][1]);
    assign {c3[1], s3[1]} = fa(s2[0], pp[2][2], pp[1][3]);
    assign {c3[2], s3[2]} = fa(s2[1], s2[2], c2[0]);
    assign {c3[3], s3[3]} = fa(c2[1], c2[2], s2[3]);
    assign {c3[4], s3[4]} = fa(c2[3], c2[4], s2[5]);
    assign {c3[5], s3[5]} = fa(c2[5], c2[6], s2[7]);
    assign {c3[6], s3[6]} = fa(c2[7], c2[8], s2[9]);
    assign {c3[7], s3[7]} = fa(c2[9], c2[10], s2[11]);
    assign {c3[8], s3[8]} = fa(c2[11], c2[12], s2[13]);
    assign {c3[9], s3[9]} = fa(pp[7][5], pp[6][6], pp[5][7]);

    // 3 -> 2
    assign {c4[0], s4[0]}   = ha(pp[2][0], pp[1][1]);
    assign {c4[1], s4[1]}   = fa(s3[0], pp[1][2], pp[0][3]);
    assign {c4[2], s4[2]}   = fa(c3[0], s3[1], pp[0][4]);
    assign {c4[3], s4[3]}   = fa(c3[1], s3[2], pp[0][5]);
    assign {c4[4], s4[4]}   = fa(c3[2], s3[3], s2[4]);
    assign {c4[5], s4[5]}   = fa(c3[3], s3[4], s2[6]);
    assign {c4[6], s4[6]}   = fa(c3[4], s3[5], s2[8]);
    assign {c4[7], s4[7]}   = fa(c3[5], s3[6], s2[10]);
    assign {c4[8], s4[8]}   = fa(c3[6], s3[7], s2[12]);
    assign {c4[9], s4[9]}   = fa(c3[7], s3[8], pp[4][7]);
    assign {c4[10], s4[10]} = fa(c3[8], s3[9], c2[13]);
    assign {c4[11], s4[11]} = fa(c3[9], pp[7][6], pp[6][7]);

    // final two rows through a ripple carry
    assign y[0] = pp[0][0];
    assign {c5[0], y[1]}   = ha(pp[1][0], pp[0][1]);
    assign {c5[1], y[2]}   = fa(s4[0], pp[0][2], c5[0]);
    assign {c5[2], y[3]}   = fa(c4[0], s4[1], c5[1]);
    assign {c5[3], y[4]}   = fa(c4[1], s4[2], c5[2]);
    assign {c5[4], y[5]}   = fa(c4[2], s4[3], c5[3]);
    assign {c5[5], y[6]}   = fa(c4[3], s4[4], c5[4]);
    assign {c5[6], y[7]}   = fa(c4[4], s4[5], c5[5]);
    assign {c5[7], y[8]}   = fa(c4[5], s4[6], c5[6]);
    assign {c5[8], y[9]}   = fa(c4[6], s4[7], c5[7]);
    assign {c5[9], y[10]}  = fa(c4[7], s4[8], c5[8]);
    assign {c5[10], y[11]} = fa(c4[8], s4[9], c5[9]);
    assign {c5[11], y[12]} = fa(c4[9], s4[10], c5[10]);
    assign {c5[12], y[13]} = fa(c4[10], s4[11], c5[11]);
    assign {c5[13], y[14]} = fa(c4[11], pp[7][7], c5[12]);
    assign y[15] = c5[13];

endmodule

//--- rtl/mul_pkg.sv
/* types shared by the multiplier, sized from the constants header */
`include "mul_consts.svh"

package mul_pkg;

    typedef logic [`MUL_WIDTH-1:0] operand_t;
    typedef logic [`MUL_HALF-1:0] half_t;

    // a 16x16 product fills one word
    typedef logic [`MUL_WIDTH-1:0] partial_t;
    typedef logic [2*`MUL_WIDTH-1:0] product_t;

    typedef logic [$clog2(`MUL_STEPS)-1:0] step_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_t;

endpackage

//--- rtl/mul_consts.svh
/* widths and timing of the four-pass 32x32 unsigned multiplier.
   latency counts rising edges from the edge that samples start to the one that sees done */
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand width and the two split widths below it
`define MUL_WIDTH 32
`define MUL_HALF 16
`define MUL_LEAF 8

// one pass through the 16x16 array per pair of halves
`define MUL_STEPS 4

// edge 0 samples start, done is seen at edge 5
`define MUL_LATENCY 5

`endif
